//--- build.f
+incdir+logic
logic/pit_pkg.sv
logic/pit_program_regs.sv
logic/pit_event_detect.sv
logic/pit_count_engine.sv
logic/pit_readback.sv
logic/pit_counter_top.sv
tb/pit_counter_checker.sv
tb/pit_counter_tb.sv

//--- logic/pit_count_engine.sv
`timescale 1ns/1ps
`default_nettype none

module pit_count_engine (
    input  logic                   clock,
    input  logic                   reset,
    input  pit_pkg::counter_mode_e mode,
    input  pit_pkg::count_t        preset,
    input  logic                   count_written,
    input  logic                   control_written,
    input  pit_pkg::pit_events_t   events,
    output pit_pkg::count_t        count,
    output logic                   counter_out
);

    pit_pkg::engine_state_e state;
    pit_pkg::count_t        count_dec;
    logic                   rate_mode;
    logic                   count_is_one;

    assign count_dec    = count - pit_pkg::count_t'(1);
    assign rate_mode    = (mode == pit_pkg::mode_rate);
    assign count_is_one = (count == pit_pkg::count_t'(1));

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= pit_pkg::st_idle;
            count       <= '0;
            counter_out <= 1'b0;
        end else if (control_written) begin
            // Mode 0 drops the output, mode 2 idles high
            state       <= pit_pkg::st_idle;
            counter_out <= rate_mode;
        end else if (count_written) begin
            state       <= pit_pkg::st_armed;
            counter_out <= rate_mode;
        end else begin
            case (state)
                pit_pkg::st_armed: begin
                    if (events.tick) begin
                        count <= preset;
                        state <= pit_pkg::st_counting;
                    end
                end
                pit_pkg::st_counting: begin
                    if (rate_mode) begin
                        if (!events.gate) begin
                            // Held count, output forced high
                            counter_out <= 1'b1;
                        end else if (events.tick) begin
                            if (count_is_one) begin
                                count       <= preset;
                                counter_out <= 1'b1;
                            end else begin
                                count       <= count_dec;
                                counter_out <= (count_dec != pit_pkg::count_t'(1));
                            end
                        end
                    end else if (events.tick && events.gate) begin
                        count <= count_dec;
                        // Sticky high once terminal count is reached
                        if (count_dec == '0) begin
                            counter_out <= 1'b1;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/pit_counter_top.sv
`timescale 1ns/1ps
`default_nettype none

module pit_counter_top (
    input  logic               clock,
    input  logic               reset,
    input  pit_pkg::bus_byte_t data_in,
    input  logic               write_control,
    input  logic               write_counter,
    input  logic               read_counter,
    input  logic               counter_clock,
    input  logic               counter_gate,
    output pit_pkg::bus_byte_t read_data,
    output logic               counter_out
);

    pit_pkg::pit_ctrl_t   ctrl;
    pit_pkg::count_t      preset;
    pit_pkg::count_t      count;
    pit_pkg::pit_events_t events;
    logic                 count_written;
    logic                 latch_cmd;
    logic                 control_written;

    pit_program_regs u_program_regs (
        .clock           (clock),
        .reset           (reset),
        .data_in         (data_in),
        .write_control   (write_control),
        .write_counter   (write_counter),
        .ctrl            (ctrl),
        .preset          (preset),
        .count_written   (count_written),
        .latch_cmd       (latch_cmd),
        .control_written (control_written)
    );

    pit_event_detect u_event_detect (
        .clock         (clock),
        .reset         (reset),
        .counter_clock (counter_clock),
        .counter_gate  (counter_gate),
        .events        (events)
    );

    pit_count_engine u_count_engine (
        .clock           (clock),
        .reset           (reset),
        .mode            (ctrl.mode),
        .preset          (preset),
        .count_written   (count_written),
        .control_written (control_written),
        .events          (events),
        .count           (count),
        .counter_out     (counter_out)
    );

    pit_readback u_readback (
        .clock           (clock),
        .reset           (reset),
        .rw_sel          (ctrl.rw_sel),
        .count           (count),
        .latch_cmd       (latch_cmd),
        .control_written (control_written),
        .read_counter    (read_counter),
        .read_data       (read_data)
    );

endmodule

`default_nettype wire

//--- logic/pit_event_detect.sv
`timescale 1ns/1ps
`default_nettype none

module pit_event_detect (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 counter_clock,
    input  logic                 counter_gate,
    output pit_pkg::pit_events_t events
);

    logic prev_counter_clock;
    logic falling_edge;

    assign falling_edge = prev_counter_clock && !counter_clock;

    always_ff @(posedge clock) begin
        if (reset) begin
            prev_counter_clock <= 1'b0;
        end else begin
            prev_counter_clock <= counter_clock;
        end
    end

    // Tick and gate sampled on the same edge
    always_ff @(posedge clock) begin
        if (reset) begin
            events.tick <= 1'b0;
            events.gate <= 1'b0;
        end else begin
            events.tick <= falling_edge;
            events.gate <= counter_gate;
        end
    end

endmodule

`default_nettype wire

//--- logic/pit_pkg.sv
`default_nettype none

`include "pit_settings.svh"

package pit_pkg;

    typedef logic [`PIT_DATA_WIDTH-1:0] bus_byte_t;
    typedef logic [`PIT_COUNT_WIDTH-1:0] count_t;

    // Encoding follows the read/load field of the control word
    typedef enum logic [1:0] {
        rw_latch   = 2'b00,
        rw_lsb     = 2'b01,
        rw_msb     = 2'b10,
        rw_lsb_msb = 2'b11
    } rw_sel_e;

    typedef enum logic {
        mode_terminal = 1'b0,
        mode_rate     = 1'b1
    } counter_mode_e;

    typedef enum logic [1:0] {
        st_idle,
        st_armed,
        st_counting
    } engine_state_e;

    typedef struct packed {
        rw_sel_e       rw_sel;
        counter_mode_e mode;
    } pit_ctrl_t;

    typedef struct packed {
        logic tick;
        logic gate;
    } pit_events_t;

endpackage

`default_nettype wire

//--- logic/pit_program_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "pit_settings.svh"

module pit_program_regs (
    input  logic               clock,
    input  logic               reset,
    input  pit_pkg::bus_byte_t data_in,
    input  logic               write_control,
    input  logic               write_counter,
    output pit_pkg::pit_ctrl_t ctrl,
    output pit_pkg::count_t    preset,
    output logic               count_written,
    output logic               latch_cmd,
    output logic               control_written
);

    pit_pkg::rw_sel_e                          cw_rw_sel;
    logic [`PIT_CW_MODE_HI-`PIT_CW_MODE_LO:0]  cw_mode_code;
    pit_pkg::counter_mode_e                    cw_mode;
    logic                                      is_latch_word;
    logic                                      program_word;
    logic                                      msb_step;

    assign cw_rw_sel    = pit_pkg::rw_sel_e'(data_in[`PIT_CW_RW_HI:`PIT_CW_RW_LO]);
    assign cw_mode_code = data_in[`PIT_CW_MODE_HI:`PIT_CW_MODE_LO];
    assign is_latch_word = (cw_rw_sel == pit_pkg::rw_latch);
    assign program_word  = write_control && !is_latch_word;

    // Only modes 2 and 6 run as rate generator
    always_comb begin
        if ((cw_mode_code == `PIT_MODE2_CODE) || (cw_mode_code == `PIT_MODE2_ALT_CODE)) begin
            cw_mode = pit_pkg::mode_rate;
        end else begin
            cw_mode = pit_pkg::mode_terminal;
        end
    end

    // Control register and command pulses
    always_ff @(posedge clock) begin
        if (reset) begin
            ctrl.rw_sel     <= pit_pkg::rw_msb;
            ctrl.mode       <= pit_pkg::mode_terminal;
            latch_cmd       <= 1'b0;
            control_written <= 1'b0;
        end else begin
            latch_cmd       <= write_control && is_latch_word;
            control_written <= program_word;
            if (program_word) begin
                ctrl.rw_sel <= cw_rw_sel;
                ctrl.mode   <= cw_mode;
            end
        end
    end

    // Preset bytes, low byte first in two-byte mode
    always_ff @(posedge clock) begin
        if (reset) begin
            preset        <= '0;
            msb_step      <= 1'b0;
            count_written <= 1'b0;
        end else begin
            count_written <= 1'b0;
            if (program_word) begin
                msb_step <= 1'b0;
            end else if (write_counter) begin
                case (ctrl.rw_sel)
                    pit_pkg::rw_lsb: begin
                        preset        <= pit_pkg::count_t'(data_in);
                        count_written <= 1'b1;
                    end
                    pit_pkg::rw_msb: begin
                        preset        <= {data_in, {`PIT_DATA_WIDTH{1'b0}}};
                        count_written <= 1'b1;
                    end
                    pit_pkg::rw_lsb_msb: begin
                        if (!msb_step) begin
                            preset[`PIT_DATA_WIDTH-1:0] <= data_in;
                            msb_step                    <= 1'b1;
                        end else begin
                            preset[`PIT_COUNT_WIDTH-1:`PIT_DATA_WIDTH] <= data_in;
                            msb_step                                    <= 1'b0;
                            count_written                               <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/pit_readback.sv
`timescale 1ns/1ps
`default_nettype none

`include "pit_settings.svh"

module pit_readback (
    input  logic               clock,
    input  logic               reset,
    input  pit_pkg::rw_sel_e   rw_sel,
    input  pit_pkg::count_t    count,
    input  logic               latch_cmd,
    input  logic               control_written,
    input  logic               read_counter,
    output pit_pkg::bus_byte_t read_data
);

    pit_pkg::count_t latched;
    logic            frozen;
    logic            read_step;
    logic            last_read;

    // Last byte of the selected read sequence
    assign last_read = (rw_sel != pit_pkg::rw_lsb_msb) || read_step;

    always_comb begin
        case (rw_sel)
            pit_pkg::rw_msb:     read_data = latched[`PIT_COUNT_WIDTH-1:`PIT_DATA_WIDTH];
            pit_pkg::rw_lsb_msb: read_data = read_step ?
                                             latched[`PIT_COUNT_WIDTH-1:`PIT_DATA_WIDTH] :
                                             latched[`PIT_DATA_WIDTH-1:0];
            default:             read_data = latched[`PIT_DATA_WIDTH-1:0];
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            latched   <= '0;
            frozen    <= 1'b0;
            read_step <= 1'b0;
        end else begin
            if (!frozen) begin
                latched <= count;
            end
            if (latch_cmd) begin
                frozen <= 1'b1;
            end else if (read_counter && last_read) begin
                frozen <= 1'b0;
            end
            if (control_written) begin
                read_step <= 1'b0;
            end else if (read_counter && (rw_sel == pit_pkg::rw_lsb_msb)) begin
                read_step <= !read_step;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/pit_settings.svh
`ifndef PIT_SETTINGS_SVH
`define PIT_SETTINGS_SVH

// Bus byte and counter widths
`define PIT_DATA_WIDTH 8
`define PIT_COUNT_WIDTH 16

// Read/load field of the control word
`define PIT_CW_RW_HI 5
`define PIT_CW_RW_LO 4

// Mode field of the control word
`define PIT_CW_MODE_HI 3
`define PIT_CW_MODE_LO 1

// Mode codes that select the rate generator
`define PIT_MODE2_CODE 3'd2
`define PIT_MODE2_ALT_CODE 3'd6

`endif

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module pit_counter_tb -o sim_pit

output=$(./obj_dir/sim_pit 2>&1 || true)
echo "$output"

if echo "$output" | grep -qF "*** PASSED ***"; then
    exit 0
fi
exit 1

//--- tb/pit_counter_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pit_counter_checker (
    input logic                 clock,
    input logic                 reset,
    input logic                 counter_out,
    input pit_pkg::pit_events_t events,
    input pit_pkg::pit_ctrl_t   ctrl,
    input logic                 control_written,
    input logic                 count_written
);

    reset_clears_output: assert property (@(posedge clock) reset |=> !counter_out)
        else $error("counter_out not low in the cycle after reset");

    single_cycle_tick: assert property (@(posedge clock) disable iff (reset)
        events.tick |=> !events.tick)
        else $error("count tick high in two consecutive cycles");

    // Mode 0 output is sticky until the next control word or count write
    terminal_output_holds: assert property (@(posedge clock) disable iff (reset)
        (ctrl.mode == pit_pkg::mode_terminal && counter_out && !control_written
         && !count_written) |=> counter_out)
        else $error("mode 0 output fell without a control word or count write");

endmodule

bind pit_counter_top pit_counter_checker u_checker (
    .clock           (clock),
    .reset           (reset),
    .counter_out     (counter_out),
    .events          (events),
    .ctrl            (ctrl),
    .control_written (control_written),
    .count_written   (count_written)
);

`default_nettype wire

//--- tb/pit_counter_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pit_counter_tb;

    logic               clock;
    logic               reset;
    pit_pkg::bus_byte_t data_in;
    logic               write_control;
    logic               write_counter;
    logic               read_counter;
    logic               counter_clock;
    logic               counter_gate;
    pit_pkg::bus_byte_t read_data;
    logic               counter_out;
    int                 test_errors;
    int                 total_errors;
    int                 tests_run;
    int                 tests_failed;

    pit_counter_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic write_cw(input pit_pkg::bus_byte_t word);
        @(negedge clock);
        data_in       = word;
        write_control = 1'b1;
        @(negedge clock);
        write_control = 1'b0;
        data_in       = '0;
    endtask

    task automatic write_count(input pit_pkg::bus_byte_t value);
        @(negedge clock);
        data_in       = value;
        write_counter = 1'b1;
        @(negedge clock);
        write_counter = 1'b0;
        data_in       = '0;
    endtask

    // read_data is combinational, valid while the strobe is high
    task automatic read_byte(output pit_pkg::bus_byte_t value);
        @(negedge clock);
        read_counter = 1'b1;
        #1 value = read_data;
        @(negedge clock);
        read_counter = 1'b0;
    endtask

    task automatic pulse_counter_clock();
        @(negedge clock);
        counter_clock = 1'b1;
        repeat (3) @(negedge clock);
        counter_clock = 1'b0;
        repeat (3) @(negedge clock);
    endtask

    task automatic expect_value(input string what, input int actual, input int expected);
        if (actual != expected) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
            test_errors++;
        end
    endtask

    task automatic wait_out(input logic level, input int limit);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge clock);
            seen = (counter_out == level);
        end
        if (!seen) begin
            $display("Timeout: counter_out did not reach %b within %0d cycles", level, limit);
            test_errors++;
        end
    endtask

    task automatic close_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    function automatic int pick_preset();
        return 3 + int'($urandom % 38);
    endfunction

    task automatic load_two_bytes(input int n);
        write_count(pit_pkg::bus_byte_t'(n));
        write_count(pit_pkg::bus_byte_t'(n >> 8));
    endtask

    task automatic reset_state_test();
        expect_value("counter_out after reset", int'(counter_out), 0);
        expect_value("read_data after reset", int'(read_data), 0);
        close_test("reset_state");
    endtask

    // Mode 0, LSB then MSB
    task automatic terminal_count_test();
        int n;
        n = pick_preset();
        counter_gate = 1'b1;
        write_cw(8'h30);
        load_two_bytes(n);
        for (int i = 1; i <= n; i++) begin
            pulse_counter_clock();
            expect_value($sformatf("counter_out after tick %0d", i), int'(counter_out), 0);
        end
        pulse_counter_clock();
        expect_value("counter_out after terminal tick", int'(counter_out), 1);
        for (int i = 1; i <= 3; i++) begin
            pulse_counter_clock();
            expect_value("counter_out after terminal count", int'(counter_out), 1);
        end
        close_test("terminal_count");
    endtask

    task automatic gate_hold_test();
        int n;
        n = pick_preset();
        counter_gate = 1'b1;
        write_cw(8'h30);
        load_two_bytes(n);
        pulse_counter_clock();
        expect_value("counter_out after load tick", int'(counter_out), 0);
        counter_gate = 1'b0;
        repeat (5) begin
            pulse_counter_clock();
            expect_value("counter_out with gate low", int'(counter_out), 0);
        end
        counter_gate = 1'b1;
        for (int i = 2; i <= n; i++) begin
            pulse_counter_clock();
            expect_value($sformatf("counter_out after gated tick %0d", i), int'(counter_out), 0);
        end
        pulse_counter_clock();
        expect_value("counter_out after gated terminal tick", int'(counter_out), 1);
        close_test("gate_hold");
    endtask

    // Mode 2, LSB only
    task automatic rate_gen_test();
        int n;
        int lows;
        int expected;
        n    = pick_preset();
        lows = 0;
        counter_gate = 1'b1;
        write_cw(8'h14);
        wait_out(1'b1, 4);
        write_count(pit_pkg::bus_byte_t'(n));
        pulse_counter_clock();
        expect_value("counter_out after load tick", int'(counter_out), 1);
        for (int j = 1; j <= 3 * n; j++) begin
            pulse_counter_clock();
            expected = (j % n == n - 1) ? 0 : 1;
            lows += 1 - int'(counter_out);
            expect_value($sformatf("rate output after tick %0d", j), int'(counter_out), expected);
        end
        expect_value("low ticks over 3 periods", lows, 3);
        repeat (n - 1) pulse_counter_clock();
        expect_value("rate output before gate drop", int'(counter_out), 0);
        counter_gate = 1'b0;
        wait_out(1'b1, 2);
        counter_gate = 1'b1;
        close_test("rate_gen");
    endtask

    task automatic latch_read_test();
        int                 n;
        pit_pkg::bus_byte_t lsb;
        pit_pkg::bus_byte_t msb;
        n = pick_preset();
        counter_gate = 1'b1;
        write_cw(8'h30);
        load_two_bytes(n);
        repeat (3) pulse_counter_clock();
        write_cw(8'h00);
        repeat (2) pulse_counter_clock();
        read_byte(lsb);
        read_byte(msb);
        expect_value("latched count", int'({msb, lsb}), (n - 2) & 32'hFFFF);
        pulse_counter_clock();
        read_byte(lsb);
        read_byte(msb);
        expect_value("live count", int'({msb, lsb}), (n - 5) & 32'hFFFF);
        close_test("latch_read");
    endtask

    initial begin
        void'($urandom(39));
        test_errors   = 0;
        total_errors  = 0;
        tests_run     = 0;
        tests_failed  = 0;
        reset         = 1'b1;
        data_in       = '0;
        write_control = 1'b0;
        write_counter = 1'b0;
        read_counter  = 1'b0;
        counter_clock = 1'b0;
        counter_gate  = 1'b1;
        repeat (2) @(negedge clock);
        reset = 1'b0;
        reset_state_test();
        terminal_count_test();
        gate_hold_test();
        rate_gen_test();
        latch_read_test();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
